//--- source/calc_pkg.sv
package calc_pkg;

    // Datapath widths
    localparam int data_w  = 16;                // Operand and result width
    localparam int digit_w = 4;                 // Keypad code width
    localparam int op_w    = 3;                 // One-hot operator width

    // Largest keypad code that is a decimal digit
    localparam logic [digit_w-1:0] digit_max = 4'd9;

    // One-hot operator codes as keyed
    localparam logic [op_w-1:0] op_add = 3'b001;  // Addition
    localparam logic [op_w-1:0] op_sub = 3'b010;  // Subtraction
    localparam logic [op_w-1:0] op_mul = 3'b100;  // Multiplication

    // Unit latencies
    localparam int add_cycles = 1;              // Start to finish of add/sub
    localparam int mul_cycles = 16;             // Multiplier iterations
    localparam int cnt_w      = $clog2(mul_cycles); // Iteration counter width

    // Last value of the iteration counter
    localparam logic [cnt_w-1:0] mul_last = cnt_w'(mul_cycles - 1);

endpackage

//--- source/calc_job_if.sv
interface calc_job_if;

    logic                        valid;  // One-cycle job strobe
    logic [calc_pkg::data_w-1:0] opa;    // First operand
    logic [calc_pkg::data_w-1:0] opb;    // Second operand
    logic [calc_pkg::op_w-1:0]   op;     // One-hot operator
    logic                        busy;   // Sequencer has a job in flight

    // Digit entry side
    modport producer (
        output valid,
        output opa,
        output opb,
        output op,
        input  busy
    );

    // Sequencer side
    modport consumer (
        input  valid,
        input  opa,
        input  opb,
        input  op,
        output busy
    );

endinterface

//--- source/add_sub_unit.sv
module add_sub_unit (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,   // One-cycle request
    input  logic [calc_pkg::data_w-1:0] a,
    input  logic [calc_pkg::data_w-1:0] b,
    input  logic                        sub,     // High selects a minus b
    output logic [calc_pkg::data_w-1:0] result,  // Wraps modulo 2^16
    output logic                        finish   // Valid with result
);

    logic [calc_pkg::add_cycles-1:0] done_pipe;  // Start delayed by unit latency

    assign finish = done_pipe[calc_pkg::add_cycles-1];

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            done_pipe <= '0;
        else
            done_pipe <= calc_pkg::add_cycles'({done_pipe, start}); // Shift toward finish
    end

    // Two's complement subtract wraps the same way as add
    always_ff @(posedge clk) begin
        if (start) begin
            if (sub)
                result <= a - b;
            else
                result <= a + b;
        end
    end

endmodule

//--- source/shift_add_multiplier.sv
module shift_add_multiplier (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,    // Loads operands
    input  logic [calc_pkg::data_w-1:0] a,
    input  logic [calc_pkg::data_w-1:0] b,
    output logic [calc_pkg::data_w-1:0] product,  // Low 16 bits of a*b
    output logic                        finish    // Last iteration cycle
);

    logic                        running;
    logic [calc_pkg::cnt_w-1:0]  count;           // Iteration index
    logic [calc_pkg::data_w-1:0] mcand;           // Multiplicand shifts left
    logic [calc_pkg::data_w-1:0] mplier;          // Multiplier shifts right
    logic [calc_pkg::data_w-1:0] acc;
    logic [calc_pkg::data_w-1:0] partial;
    logic [calc_pkg::data_w-1:0] acc_next;

    assign partial  = mplier[0] ? mcand : '0;     // Conditional add term
    assign acc_next = acc + partial;
    assign product  = acc_next;                   // Includes the final add
    assign finish   = running && (count == calc_pkg::mul_last);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running <= 1'b1;
            count   <= '0;
        end else if (running) begin
            if (count == calc_pkg::mul_last)
                running <= 1'b0;                  // Done after this cycle
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;                 // Upper bits drop off
            mplier <= mplier >> 1;
        end
    end

    // Sequencer holds off new work until finish
    a_no_start_running: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !running);

endmodule

//--- source/digit_entry.sv
module digit_entry (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic                         key_strobe,      // One pulse per key
    input  logic [calc_pkg::digit_w-1:0] keypad_input,    // Keypad code
    input  logic [calc_pkg::op_w-1:0]    operator_input,  // Sampled every cycle
    input  logic                         equal_input,     // Equal pulse
    calc_job_if.producer                 job
);

    typedef enum logic {
        ph_first,                                // Building first operand
        ph_second                                // Building second operand
    } phase_t;

    phase_t                      phase;
    logic [calc_pkg::data_w-1:0] opa;            // Operand under entry
    logic [calc_pkg::data_w-1:0] opb;
    logic [calc_pkg::op_w-1:0]   op_q;           // Operator latched at phase change
    logic [calc_pkg::data_w-1:0] digit_ext;
    logic                        digit_ok;
    logic                        op_ok;
    logic                        equal_ok;

    assign digit_ext = calc_pkg::data_w'(keypad_input);
    assign digit_ok  = key_strobe && (keypad_input <= calc_pkg::digit_max); // Codes 10..15 dropped

    // Only an exact operator code counts and only in the first phase
    assign op_ok = (phase == ph_first) &&
                   ((operator_input == calc_pkg::op_add) ||
                    (operator_input == calc_pkg::op_sub) ||
                    (operator_input == calc_pkg::op_mul));

    assign equal_ok = (phase == ph_second) && equal_input && !job.busy; // Held off while busy

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            phase     <= ph_first;
            opa       <= '0;
            opb       <= '0;
            job.valid <= 1'b0;
        end else begin
            job.valid <= equal_ok;               // Strobe the cycle after equal
            if (equal_ok) begin
                phase <= ph_first;               // Ready for the next job
                opa   <= '0;
                opb   <= '0;
            end else if (phase == ph_first) begin
                if (op_ok)
                    phase <= ph_second;
                if (digit_ok)
                    opa <= (opa << 3) + (opa << 1) + digit_ext; // Times ten plus digit
            end else begin
                if (digit_ok)
                    opb <= (opb << 3) + (opb << 1) + digit_ext;
            end
        end
    end

    // Job payload held until the next equal
    always_ff @(posedge clk) begin
        if (op_ok)
            op_q <= operator_input;
        if (equal_ok) begin
            job.opa <= opa;
            job.opb <= opb;
            job.op  <= op_q;
        end
    end

    // Sequencer must be free whenever a job is issued
    a_valid_not_busy: assert property (@(posedge clk) disable iff (!nRST)
        job.valid |-> !job.busy);

endmodule

//--- source/calc_sequencer.sv
module calc_sequencer (
    input  logic                        clk,
    input  logic                        nRST,
    calc_job_if.consumer                job,
    output logic                        complete,        // One pulse per result
    output logic [calc_pkg::data_w-1:0] display_output   // Last result shown
);

    typedef enum logic [1:0] {
        st_idle,                                 // Waiting for a job
        st_running,                              // One unit is computing
        st_show                                  // Result just loaded
    } state_t;

    state_t                      state;
    logic [calc_pkg::data_w-1:0] opa_q;          // Copied job operands
    logic [calc_pkg::data_w-1:0] opb_q;
    logic [calc_pkg::op_w-1:0]   op_q;
    logic                        accept;
    logic                        sub;
    logic                        add_start;
    logic                        mul_start;
    logic [calc_pkg::data_w-1:0] add_result;
    logic [calc_pkg::data_w-1:0] mul_product;
    logic                        add_finish;
    logic                        mul_finish;
    logic                        unit_finish;
    logic [calc_pkg::data_w-1:0] result_sel;

    assign accept      = job.valid && (state != st_running);
    assign sub         = (op_q == calc_pkg::op_sub);
    assign unit_finish = add_finish || mul_finish;
    assign result_sel  = (op_q == calc_pkg::op_mul) ? mul_product : add_result;
    assign job.busy    = (state == st_running);
    assign complete    = (state == st_show);  // Show lasts exactly one cycle

    add_sub_unit u_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (add_start),
        .a      (opa_q),
        .b      (opb_q),
        .sub    (sub),
        .result (add_result),
        .finish (add_finish)
    );

    shift_add_multiplier u_mul (
        .clk     (clk),
        .nRST    (nRST),
        .start   (mul_start),
        .a       (opa_q),
        .b       (opb_q),
        .product (mul_product),
        .finish  (mul_finish)
    );

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= st_idle;
            add_start      <= 1'b0;
            mul_start      <= 1'b0;
            display_output <= '0;
        end else begin
            // Start goes to exactly one unit
            add_start <= accept && ((job.op == calc_pkg::op_add) ||
                                    (job.op == calc_pkg::op_sub));
            mul_start <= accept && (job.op == calc_pkg::op_mul);
            case (state)
                st_running: begin
                    if (unit_finish) begin
                        state          <= st_show;
                        display_output <= result_sel;  // Held until next result
                    end
                end
                default: state <= accept ? st_running : st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opa_q <= job.opa;
            opb_q <= job.opb;
            op_q  <= job.op;
        end
    end

    a_op_onehot: assert property (@(posedge clk) disable iff (!nRST)
        job.valid |-> $onehot(job.op));

    // Units only finish jobs this sequencer started
    a_finish_running: assert property (@(posedge clk) disable iff (!nRST)
        unit_finish |-> (state == st_running));

endmodule

//--- source/calc_top.sv
module calc_top (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic                         key_strobe,      // Marks a keyed digit
    input  logic [calc_pkg::digit_w-1:0] keypad_input,
    input  logic [calc_pkg::op_w-1:0]    operator_input,  // One-hot operator
    input  logic                         equal_input,
    output logic                         complete,
    output logic [calc_pkg::data_w-1:0]  display_output
);

    calc_job_if job_if ();                       // Entry to sequencer link

    // Operand entry stage
    digit_entry u_digit_entry (
        .clk            (clk),
        .nRST           (nRST),
        .key_strobe     (key_strobe),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .job            (job_if.producer)
    );

    // Sequencing and arithmetic stage
    calc_sequencer u_calc_sequencer (
        .clk            (clk),
        .nRST           (nRST),
        .job            (job_if.consumer),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

//--- sim/calc_tb.sv
module calc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                         clk;
    logic                         nRST;
    logic                         key_strobe;
    logic [calc_pkg::digit_w-1:0] keypad_input;
    logic [calc_pkg::op_w-1:0]    operator_input;
    logic                         equal_input;
    logic                         complete;
    logic [calc_pkg::data_w-1:0]  display_output;

    logic [7:0] cmd_q[$];                        // Trace command letters
    int         val_q[$];                        // Trace values
    int         errors      = 0;
    int         cycle_count = 0;                 // Rising edges so far
    int         eq_cycle    = 0;                 // Edge that sampled the marked equal
    bit         trace_ready = 1'b0;

    calc_top u_calc_top (
        .clk            (clk),
        .nRST           (nRST),
        .key_strobe     (key_strobe),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                        // 10 ns period

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic load_trace();
        int               fd;
        int               val;
        int               got;
        logic [7:0]       cmd;
        logic [8*128-1:0] rest;
        fd = $fopen("sim/calc_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open trace file sim/calc_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                got = $fscanf(fd, " %c", cmd);
                if (got == 1 && cmd == "#")
                    got = $fgets(rest, fd);      // Rest of a comment line
                else if (got == 1 && $fscanf(fd, "%d", val) == 1) begin
                    cmd_q.push_back(cmd);
                    val_q.push_back(val);
                end
            end
            $fclose(fd);
        end
    endtask

    // One key press, with or without the strobe
    task automatic press_key(input int code, input logic strobe);
        @(posedge clk);
        #1;
        keypad_input = code[calc_pkg::digit_w-1:0];
        key_strobe   = strobe;
        @(posedge clk);
        #1;
        key_strobe   = 1'b0;
    endtask

    task automatic apply_operator(input int code);
        @(posedge clk);
        #1;
        operator_input = code[calc_pkg::op_w-1:0];
        @(posedge clk);
        #1;
        operator_input = '0;                     // Not a valid code
    endtask

    task automatic pulse_equal(input int mark);
        @(posedge clk);
        #1;
        equal_input = 1'b1;
        @(posedge clk);                          // Edge that samples equal
        #1;
        equal_input = 1'b0;
        if (mark != 0)
            eq_cycle = cycle_count;              // Latency reference
    endtask

    task automatic wait_complete(input int latency);
        int waited;
        int seen;
        waited = 0;
        @(negedge clk);
        while (complete !== 1'b1 && waited < 40) begin
            waited++;
            @(negedge clk);
        end
        seen = cycle_count - eq_cycle + 1;       // Nth negedge after equal edge
        assert (complete === 1'b1) else begin
            errors++;
            $display("No complete pulse seen within 40 cycles, at %0d ns", $time);
        end
        if (complete === 1'b1 && latency != 0) begin
            assert (seen == latency) else begin
                errors++;
                $display("Mismatch at %0d ns: complete latency expected %0d, got %0d",
                         $time, latency, seen);
            end
        end
        @(negedge clk);
        assert (complete === 1'b0) else begin
            errors++;
            $display("Complete stayed high for more than one cycle, at %0d ns", $time);
        end
    endtask

    task automatic check_display(input int value);
        logic [calc_pkg::data_w-1:0] expected;
        expected = value[calc_pkg::data_w-1:0];
        @(negedge clk);
        assert (display_output === expected) else begin
            errors++;
            $display("Mismatch at %0d ns: display expected %0d, got %0d",
                     $time, expected, display_output);
        end
    endtask

    // Complete must stay low for the whole window
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (complete === 1'b0) else begin
                errors++;
                $display("Unexpected complete pulse at %0d ns", $time);
            end
        end
    endtask

    task automatic run_command(input logic [7:0] cmd, input int val);
        case (cmd)
            "d": press_key(val, 1'b1);
            "k": press_key(val, 1'b0);           // Key value without strobe
            "o": apply_operator(val);
            "e": pulse_equal(val);
            "w": wait_complete(val);
            "x": check_display(val);
            "n": expect_quiet(val);
            default: begin
                errors++;
                $display("Unknown trace command %c", cmd);
            end
        endcase
    endtask

    initial begin
        nRST           = 1'b0;
        key_strobe     = 1'b0;
        keypad_input   = '0;
        operator_input = '0;
        equal_input    = 1'b0;
        load_trace();
        assert (cmd_q.size() > 0) else begin
            errors++;
            $display("Trace holds no commands");
        end
        trace_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        nRST = 1'b1;
        for (int i = 0; i < cmd_q.size(); i++)
            run_command(cmd_q[i], val_q[i]);
        $display("Run finished with %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Deadline scales with the trace length
    initial begin
        wait (trace_ready);
        #((cmd_q.size() * 40 + 20) * 10);
        $display("Timeout after %0d ns, trace did not finish", $time);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- sim/calc_trace.txt
# d key digit, k key code without strobe, o operator code, e equal (1 marks latency start)
# w wait for complete (cycles after equal, 0 skips), x display value, n cycles without complete
x 0
n 5
d 1
d 2
d 3
o 1
d 4
d 5
d 6
e 1
w 4
x 579
d 5
o 2
d 9
e 1
w 4
x 65532
d 1
d 12
d 0
k 7
d 15
o 3
d 5
o 1
d 0
o 4
e 1
w 4
x 105
d 3
d 0
d 0
o 4
d 3
d 0
d 0
x 105
e 1
d 7
d 7
o 1
d 8
e 0
w 19
x 24464
n 8
e 1
w 4
x 85

//--- build.f
source/calc_pkg.sv
source/calc_job_if.sv
source/add_sub_unit.sv
source/shift_add_multiplier.sv
source/digit_entry.sv
source/calc_sequencer.sv
source/calc_top.sv
sim/calc_tb.sv

//--- Bender.yml
package:
  name: calc_core

sources:
  - source/calc_pkg.sv
  - source/calc_job_if.sv
  - source/add_sub_unit.sv
  - source/shift_add_multiplier.sv
  - source/digit_entry.sv
  - source/calc_sequencer.sv
  - source/calc_top.sv
  - target: simulation
    files:
      - sim/calc_tb.sv
